//--- include/bus_defines.svh
// ================================================
// widths, memory depth and latency, AXI response
// and size codes, reset PC and NOP instruction
// ================================================

`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// bus and core widths
`define ADDR_W      32
`define XLEN        32
`define AXI_DATA_W  64

// read memory geometry, 64-bit words
`define MEM_WORDS   256
`define MEM_LATENCY 3

`define PC_RST      32'h0000_0000
// addi x0, x0, 0
`define NOP         32'h0000_0013

`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`define SIZE_B      3'd0
`define SIZE_H      3'd1
`define SIZE_W      3'd2

`endif

//--- src/bus_pkg.sv
// ================================================
// read request and response structs, AXI AR and R
// payloads, load command and load word union
// ================================================

`include "bus_defines.svh"

package bus_pkg;

    // requester side
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [2:0]         size;
    } read_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] data;
        logic             err;
    } read_rsp_t;

    // ================================================
    // AXI4 read channels
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [3:0]         id;
        logic [7:0]         len;
        logic [2:0]         size;
        logic [1:0]         burst;
    } axi_ar_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [1:0]             resp;
        logic                   last;
        logic [3:0]             id;
    } axi_r_t;

    // ================================================
    // load side
    typedef union packed {
        logic [`XLEN-1:0] raw;
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } load_word_u;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [2:0]         size;
        logic               sign;
    } load_op_t;

endpackage

//--- src/fetch_unit.sv
// ================================================
// instruction fetch unit, sequential word reads
// from a start PC, one instruction in flight
// ================================================

`timescale 1ns/10ps

`include "bus_defines.svh"

module fetch_unit import bus_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [`ADDR_W-1:0] start_pc,
    input  logic [7:0]         count,
    output read_req_t          req,
    output logic               req_valid,
    input  logic               req_ready,
    input  read_rsp_t          rsp,
    input  logic               rsp_valid,
    output logic               rsp_ready,
    output logic [`XLEN-1:0]   inst,
    output logic [`ADDR_W-1:0] inst_pc,
    output logic               inst_err,
    output logic               inst_valid,
    input  logic               inst_ready
);

    logic [`ADDR_W-1:0] pc;
    logic [7:0]         remain;
    logic               waiting;

    // no new fetch while an instruction is still held
    assign req_valid = (remain != 8'd0) && !waiting && !inst_valid;
    assign req       = '{addr: pc, size: `SIZE_W};
    assign rsp_ready = waiting;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= `PC_RST;
            remain     <= 8'd0;
            waiting    <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            // start only taken when idle
            if (start && remain == 8'd0 && !waiting) begin
                pc     <= start_pc;
                remain <= count;
            end
            if (req_valid && req_ready) begin
                waiting <= 1'b1;
            end
            if (rsp_valid && rsp_ready) begin
                waiting    <= 1'b0;
                inst_valid <= 1'b1;
                pc         <= pc + 32'd4;
                remain     <= remain - 8'd1;
            end else if (inst_valid && inst_ready) begin
                inst_valid <= 1'b0;
            end
        end
    end

    // instruction and its pc
    always_ff @(posedge clk) begin
        if (rst) begin
            inst <= `NOP;
        end else if (rsp_valid && rsp_ready) begin
            inst <= rsp.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid && rsp_ready) begin
            inst_pc  <= pc;
            inst_err <= rsp.err;
        end
    end

endmodule

//--- src/load_unit.sv
// ================================================
// load unit, single outstanding load with byte,
// halfword and word alignment and sign extension
// ================================================

`timescale 1ns/10ps

`include "bus_defines.svh"

module load_unit import bus_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  load_op_t         op,
    input  logic             op_valid,
    output logic             op_ready,
    output read_req_t        req,
    output logic             req_valid,
    input  logic             req_ready,
    input  read_rsp_t        rsp,
    input  logic             rsp_valid,
    output logic             rsp_ready,
    output logic [`XLEN-1:0] data,
    output logic             err,
    output logic             data_valid,
    input  logic             data_ready
);

    load_op_t   op_q;
    logic       req_pend;
    logic       waiting;
    logic       misaligned;
    load_word_u word;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [`XLEN-1:0] ext_data;

    assign op_ready  = !(req_pend || waiting || data_valid);
    assign req_valid = req_pend;
    assign req       = '{addr: op_q.addr, size: op_q.size};
    assign rsp_ready = waiting;

    // unaligned or unsupported size never reaches the bus
    always_comb begin
        case (op.size)
            `SIZE_B: misaligned = 1'b0;
            `SIZE_H: misaligned = op.addr[0];
            `SIZE_W: misaligned = op.addr[1:0] != 2'b00;
            default: misaligned = 1'b1;
        endcase
    end

    // ================================================
    // lane select and extension
    assign word     = rsp.data;
    assign sel_byte = word.bytes[op_q.addr[1:0]];
    assign sel_half = word.halves[op_q.addr[1]];

    always_comb begin
        case (op_q.size)
            `SIZE_B: ext_data = {{24{op_q.sign & sel_byte[7]}}, sel_byte};
            `SIZE_H: ext_data = {{16{op_q.sign & sel_half[15]}}, sel_half};
            default: ext_data = word.raw;
        endcase
    end

    // ================================================
    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            req_pend   <= 1'b0;
            waiting    <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            if (op_valid && op_ready) begin
                req_pend   <= !misaligned;
                data_valid <= misaligned;
            end
            if (req_valid && req_ready) begin
                req_pend <= 1'b0;
                waiting  <= 1'b1;
            end
            if (rsp_valid && rsp_ready) begin
                waiting    <= 1'b0;
                data_valid <= 1'b1;
            end
            if (data_valid && data_ready) begin
                data_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_ready) begin
            op_q <= op;
            data <= '0;
            err  <= misaligned;
        end else if (rsp_valid && rsp_ready) begin
            data <= rsp.err ? '0 : ext_data;
            err  <= rsp.err;
        end
    end

endmodule

//--- src/read_arbiter.sv
// ================================================
// read arbiter, fetch and load requesters onto one
// AXI4 read channel, load has priority
// ================================================

`timescale 1ns/10ps

`include "bus_defines.svh"

module read_arbiter import bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // fetch requester
    input  read_req_t fetch_req,
    input  logic      fetch_req_valid,
    output logic      fetch_req_ready,
    output read_rsp_t fetch_rsp,
    output logic      fetch_rsp_valid,
    input  logic      fetch_rsp_ready,
    // load requester
    input  read_req_t load_req,
    input  logic      load_req_valid,
    output logic      load_req_ready,
    output read_rsp_t load_rsp,
    output logic      load_rsp_valid,
    input  logic      load_rsp_ready,
    // AXI read master
    output axi_ar_t   ar,
    output logic      arvalid,
    input  logic      arready,
    input  axi_r_t    r,
    input  logic      rvalid,
    output logic      rready
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;
    localparam logic [1:0] ST_OVER = 2'd3;

    localparam logic [3:0] ARID = 4'd0;

    logic [1:0]         state;
    logic               owner_load;
    logic [`ADDR_W-1:0] ar_addr;
    logic [2:0]         ar_size;
    logic [`XLEN-1:0]   rsp_data;
    logic               rsp_err;
    logic               fetch_hs;
    logic               load_hs;
    logic               owner_done;

    // ================================================
    // handshakes
    assign load_req_ready  = state == ST_IDLE;
    assign fetch_req_ready = state == ST_IDLE && !load_req_valid;

    assign fetch_hs = fetch_req_valid && fetch_req_ready;
    assign load_hs  = load_req_valid && load_req_ready;

    assign fetch_rsp_valid = state == ST_OVER && !owner_load;
    assign load_rsp_valid  = state == ST_OVER && owner_load;

    assign owner_done = (fetch_rsp_valid && fetch_rsp_ready)
                     || (load_rsp_valid && load_rsp_ready);

    assign fetch_rsp = '{data: rsp_data, err: rsp_err};
    assign load_rsp  = '{data: rsp_data, err: rsp_err};

    // single beat, fixed id
    assign arvalid = state == ST_ADDR;
    assign rready  = state == ST_WAIT;
    assign ar      = '{addr: ar_addr, id: ARID, len: 8'd0, size: ar_size, burst: 2'b01};

    // ================================================
    // state machine
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            owner_load <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (fetch_hs || load_hs) begin
                        state      <= ST_ADDR;
                        owner_load <= load_hs;
                    end
                end
                ST_ADDR: begin
                    if (arvalid && arready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rvalid && rready) begin
                        state <= ST_OVER;
                    end
                end
                default: begin
                    if (owner_done) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // request latch
    always_ff @(posedge clk) begin
        if (fetch_hs || load_hs) begin
            ar_addr <= load_hs ? load_req.addr : fetch_req.addr;
            ar_size <= load_hs ? load_req.size : fetch_req.size;
        end
    end

    // upper half holds the odd word
    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            rsp_data <= ar_addr[2] ? r.data[63:32] : r.data[31:0];
            rsp_err  <= (r.resp != `RESP_OKAY) || (r.id != ARID);
        end
    end

endmodule

//--- src/axi_read_mem.sv
// ================================================
// AXI4 read slave over a 64-bit word array, fixed
// latency, SLVERR out of range, preload port
// ================================================

`timescale 1ns/10ps

`include "bus_defines.svh"

module axi_read_mem import bus_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  axi_ar_t                       ar,
    input  logic                          arvalid,
    output logic                          arready,
    output axi_r_t                        r,
    output logic                          rvalid,
    input  logic                          rready,
    input  logic                          prog_we,
    input  logic [$clog2(`MEM_WORDS)-1:0] prog_addr,
    input  logic [`AXI_DATA_W-1:0]        prog_data
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    logic [`AXI_DATA_W-1:0] mem [`MEM_WORDS];

    logic                   busy;
    logic [3:0]             cnt;
    logic [IDX_W-1:0]       idx;
    logic                   oor;
    logic [3:0]             rid;
    logic [`AXI_DATA_W-1:0] rdata;
    logic                   ar_hs;
    logic                   fire;

    assign arready = !busy;
    assign ar_hs   = arvalid && arready;
    // last wait cycle before data
    assign fire    = busy && !rvalid && cnt == 4'd1;

    assign r = '{
        data: rdata,
        resp: oor ? `RESP_SLVERR : `RESP_OKAY,
        last: 1'b1,
        id:   rid
    };

    // preload
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // ================================================
    // latency counter
    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            cnt    <= 4'd0;
            rvalid <= 1'b0;
        end else begin
            if (ar_hs) begin
                busy <= 1'b1;
                cnt  <= 4'(`MEM_LATENCY - 1);
            end else if (busy && !rvalid) begin
                cnt <= cnt - 4'd1;
            end
            if (fire) begin
                rvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                busy   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            idx <= ar.addr[IDX_W+2:3];
            oor <= ar.addr >= `ADDR_W'(`MEM_WORDS * 8);
            rid <= ar.id;
        end
        if (fire) begin
            rdata <= oor ? '0 : mem[idx];
        end
    end

endmodule

//--- src/mem_read_top.sv
// ================================================
// read side top, fetch and load units through the
// arbiter to the AXI read memory
// ================================================

`timescale 1ns/10ps

`include "bus_defines.svh"

module mem_read_top import bus_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    // fetch
    input  logic                          fetch_start,
    input  logic [`ADDR_W-1:0]            fetch_pc,
    input  logic [7:0]                    fetch_count,
    output logic [`XLEN-1:0]              inst,
    output logic [`ADDR_W-1:0]            inst_pc,
    output logic                          inst_err,
    output logic                          inst_valid,
    input  logic                          inst_ready,
    // load
    input  logic                          load_valid_in,
    input  load_op_t                      load_op,
    output logic                          load_ready_out,
    output logic [`XLEN-1:0]              load_data,
    output logic                          load_err,
    output logic                          load_valid,
    input  logic                          load_ready,
    // preload
    input  logic                          prog_we,
    input  logic [$clog2(`MEM_WORDS)-1:0] prog_addr,
    input  logic [`AXI_DATA_W-1:0]        prog_data
);

    read_req_t fetch_req;
    logic      fetch_req_valid;
    logic      fetch_req_ready;
    read_rsp_t fetch_rsp;
    logic      fetch_rsp_valid;
    logic      fetch_rsp_ready;
    read_req_t load_req;
    logic      load_req_valid;
    logic      load_req_ready;
    read_rsp_t load_rsp;
    logic      load_rsp_valid;
    logic      load_rsp_ready;
    axi_ar_t   ar;
    logic      arvalid;
    logic      arready;
    axi_r_t    r;
    logic      rvalid;
    logic      rready;

    fetch_unit fetch_unit_inst (
        .clk, .rst,
        .start(fetch_start), .start_pc(fetch_pc), .count(fetch_count),
        .req(fetch_req), .req_valid(fetch_req_valid), .req_ready(fetch_req_ready),
        .rsp(fetch_rsp), .rsp_valid(fetch_rsp_valid), .rsp_ready(fetch_rsp_ready),
        .inst, .inst_pc, .inst_err, .inst_valid, .inst_ready
    );

    load_unit load_unit_inst (
        .clk, .rst,
        .op(load_op), .op_valid(load_valid_in), .op_ready(load_ready_out),
        .req(load_req), .req_valid(load_req_valid), .req_ready(load_req_ready),
        .rsp(load_rsp), .rsp_valid(load_rsp_valid), .rsp_ready(load_rsp_ready),
        .data(load_data), .err(load_err), .data_valid(load_valid), .data_ready(load_ready)
    );

    read_arbiter read_arbiter_inst (
        .clk, .rst,
        .fetch_req, .fetch_req_valid, .fetch_req_ready,
        .fetch_rsp, .fetch_rsp_valid, .fetch_rsp_ready,
        .load_req, .load_req_valid, .load_req_ready,
        .load_rsp, .load_rsp_valid, .load_rsp_ready,
        .ar, .arvalid, .arready, .r, .rvalid, .rready
    );

    axi_read_mem axi_read_mem_inst (
        .clk, .rst,
        .ar, .arvalid, .arready, .r, .rvalid, .rready,
        .prog_we, .prog_addr, .prog_data
    );

endmodule

//--- verification/mem_read_checker.sv
// ==================================================
// bound assertions on the read arbiter, AXI valid
// hold until transfer and load priority
// ==================================================

`timescale 1ns/10ps

module mem_read_checker import bus_pkg::*; (
    input logic      clk,
    input logic      rst,
    input read_req_t load_req,
    input logic      fetch_req_valid,
    input logic      load_req_valid,
    input logic      load_req_ready,
    input logic      owner_load,
    input axi_ar_t   ar,
    input logic      arvalid,
    input logic      arready,
    input logic      rvalid,
    input logic      rready
);

    // failures so far, read by the testbench
    int fail_count = 0;

    // ==================================================
    // AXI read channel
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(arvalid) |-> $past(arready))
    else begin
        fail_count++;
        $error("arvalid dropped before arready");
    end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(rvalid) |-> $past(rready))
    else begin
        fail_count++;
        $error("rvalid dropped before rready");
    end

    // ==================================================
    // arbitration
    load_first: assert property (@(posedge clk) disable iff (rst)
        load_req_valid && fetch_req_valid && load_req_ready
        |=> owner_load && arvalid && ar.addr == $past(load_req.addr))
    else begin
        fail_count++;
        $error("fetch won over a load pending in the same cycle");
    end

endmodule

bind read_arbiter mem_read_checker mem_read_checker_inst (
    .clk(clk), .rst(rst), .load_req(load_req),
    .fetch_req_valid(fetch_req_valid), .load_req_valid(load_req_valid),
    .load_req_ready(load_req_ready), .owner_load(owner_load),
    .ar(ar), .arvalid(arvalid), .arready(arready),
    .rvalid(rvalid), .rready(rready)
);

//--- verification/tb_mem_read_top.sv
// ==================================================
// testbench for the read side top, preload, fetch
// and load sequences, reference model, timeout
// ==================================================

`timescale 1ns/10ps

`include "bus_defines.svh"

module tb_mem_read_top import bus_pkg::*; ();

    localparam int IDX_W = $clog2(`MEM_WORDS);
    // reset 16 + preload 256 + about 55 reads of at most ~40 cycles with ready stalls
    localparam int MAX_CYCLES = 4000;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   fetch_start;
    logic [`ADDR_W-1:0]     fetch_pc;
    logic [7:0]             fetch_count;
    logic [`XLEN-1:0]       inst;
    logic [`ADDR_W-1:0]     inst_pc;
    logic                   inst_err;
    logic                   inst_valid;
    logic                   inst_ready;
    logic                   load_valid_in;
    load_op_t               load_op;
    logic                   load_ready_out;
    logic [`XLEN-1:0]       load_data;
    logic                   load_err;
    logic                   load_valid;
    logic                   load_ready;
    logic                   prog_we;
    logic [IDX_W-1:0]       prog_addr;
    logic [`AXI_DATA_W-1:0] prog_data;

    logic [`AXI_DATA_W-1:0] model [`MEM_WORDS];
    read_rsp_t              load_exp_q[$];
    logic [`ADDR_W-1:0]     fetch_pc_exp;
    int                     fetch_seen;
    int                     errors;
    int                     cycles;
    int                     tests_run;
    int                     tests_failed;

    mem_read_top mem_read_top_inst (.*);

    always #2 clk = ~clk;

    // ==================================================
    // reference model and checks
    function automatic read_rsp_t expect_load(input logic [`ADDR_W-1:0] addr,
                                              input logic [2:0] size, input logic sign);
        read_rsp_t        res;
        logic [`XLEN-1:0] word;
        logic [`XLEN-1:0] shifted;
        res = '{data: '0, err: 1'b0};
        if ((size == `SIZE_H && addr[0]) || (size == `SIZE_W && addr[1:0] != 2'b00)
                || addr >= `MEM_WORDS * 8) begin
            res.err = 1'b1;
            return res;
        end
        word    = addr[2] ? model[addr[IDX_W+2:3]][63:32] : model[addr[IDX_W+2:3]][31:0];
        shifted = word >> (8 * addr[1:0]);
        case (size)
            `SIZE_B: res.data = (sign && shifted[7]) ? {24'hff_ffff, shifted[7:0]}
                                                     : {24'h0, shifted[7:0]};
            `SIZE_H: res.data = (sign && shifted[15]) ? {16'hffff, shifted[15:0]}
                                                      : {16'h0, shifted[15:0]};
            default: res.data = word;
        endcase
        return res;
    endfunction

    function automatic int total_errors();
        return errors + mem_read_top_inst.read_arbiter_inst.mem_read_checker_inst.fail_count;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want)
        else begin
            $display("Error: %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : monitor
        read_rsp_t exp;
        if (!rst && load_valid_in && load_ready_out) begin
            load_exp_q.push_back(expect_load(load_op.addr, load_op.size, load_op.sign));
        end
        if (!rst && inst_valid && inst_ready) begin
            exp = expect_load(fetch_pc_exp, `SIZE_W, 1'b0);
            check_value("inst_pc", inst_pc, fetch_pc_exp);
            check_value("inst", inst, exp.data);
            check_value("inst_err", {31'h0, inst_err}, 32'h0);
            fetch_pc_exp = fetch_pc_exp + 32'd4;
            fetch_seen++;
        end
        if (!rst && load_valid && load_ready) begin
            if (load_exp_q.size() == 0) begin
                $display("load response arrived with no load outstanding");
                errors++;
            end else begin
                exp = load_exp_q.pop_front();
                check_value("load_data", load_data, exp.data);
                check_value("load_err", {31'h0, load_err}, {31'h0, exp.err});
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ==================================================
    // stimulus helpers
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_readies();
        forever begin
            step();
            inst_ready = ($urandom % 4) != 0;
            load_ready = ($urandom % 4) != 0;
        end
    endtask

    task automatic preload_memory();
        logic [`AXI_DATA_W-1:0] value;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            value        = {$urandom, $urandom};
            model[i]     = value;
            prog_we      = 1'b1;
            prog_addr    = IDX_W'(i);
            prog_data    = value;
            step();
        end
        prog_we = 1'b0;
    endtask

    task automatic issue_load(input logic [`ADDR_W-1:0] addr, input logic [2:0] size,
                              input logic sign);
        load_op       = '{addr: addr, size: size, sign: sign};
        load_valid_in = 1'b1;
        do @(negedge clk); while (!load_ready_out);
        step();
        load_valid_in = 1'b0;
    endtask

    task automatic start_fetch(input logic [`ADDR_W-1:0] pc, input logic [7:0] count);
        fetch_pc_exp = pc;
        fetch_seen   = 0;
        fetch_pc     = pc;
        fetch_count  = count;
        fetch_start  = 1'b1;
    endtask

    task automatic wait_idle(input int fetch_total);
        while (fetch_seen < fetch_total || load_exp_q.size() != 0) begin
            step();
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        if (total_errors() == errs_at_start) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s failed with %0d errors", name, total_errors() - errs_at_start);
        end
    endtask

    // ==================================================
    // tests
    task automatic run_fetch_test();
        int errs;
        errs = total_errors();
        start_fetch(32'h40, 8'd16);
        step();
        fetch_start = 1'b0;
        wait_idle(16);
        end_test("fetch_seq", errs);
    endtask

    task automatic run_load_test();
        int                 errs;
        logic [`ADDR_W-1:0] base [2];
        errs    = total_errors();
        base[0] = 32'h100;
        base[1] = 32'h10c;
        for (int b = 0; b < 2; b++) begin
            for (int s = 0; s < 2; s++) begin
                for (int o = 0; o < 4; o++) begin
                    issue_load(base[b] + o, `SIZE_B, s[0]);
                end
                for (int o = 0; o < 4; o += 2) begin
                    issue_load(base[b] + o, `SIZE_H, s[0]);
                end
                issue_load(base[b], `SIZE_W, s[0]);
            end
        end
        wait_idle(0);
        end_test("load_sizes", errs);
    endtask

    // fetch and load requests reach the arbiter in the same cycle
    task automatic run_priority_test();
        int errs;
        errs = total_errors();
        start_fetch(32'h80, 8'd4);
        issue_load(32'h1f4, `SIZE_W, 1'b1);
        fetch_start = 1'b0;
        wait_idle(4);
        end_test("priority", errs);
    endtask

    task automatic run_error_test();
        int errs;
        errs = total_errors();
        issue_load(32'h800, `SIZE_W, 1'b0);
        issue_load(32'h1000, `SIZE_B, 1'b1);
        issue_load(32'h101, `SIZE_H, 1'b1);
        issue_load(32'h102, `SIZE_W, 1'b0);
        wait_idle(0);
        end_test("load_errors", errs);
    endtask

    initial begin
        void'($urandom(59784));
        rst           = 1'b1;
        fetch_start   = 1'b0;
        fetch_pc      = '0;
        fetch_count   = '0;
        inst_ready    = 1'b0;
        load_valid_in = 1'b0;
        load_op       = '0;
        load_ready    = 1'b0;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        fetch_pc_exp  = '0;
        fetch_seen    = 0;
        errors        = 0;
        cycles        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        preload_memory();
        fork
            drive_readies();
        join_none
        run_fetch_test();
        run_load_test();
        run_priority_test();
        run_error_test();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
src/bus_pkg.sv
src/fetch_unit.sv
src/load_unit.sv
src/read_arbiter.sv
src/axi_read_mem.sv
src/mem_read_top.sv
verification/mem_read_checker.sv
verification/tb_mem_read_top.sv

//--- Bender.yml
package:
  name: mem_read

export_include_dirs:
  - include

sources:
  - files:
      - src/bus_pkg.sv
      - src/fetch_unit.sv
      - src/load_unit.sv
      - src/read_arbiter.sv
      - src/axi_read_mem.sv
      - src/mem_read_top.sv
  - target: test
    files:
      - verification/mem_read_checker.sv
      - verification/tb_mem_read_top.sv
